/* hw/riscv_settings.svh */
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// Datapath width
`define XLEN 32

// Byte address width shared by both memories (4 KB each)
`define ADDR_W 12

// Register index width, 32 architectural registers
`define REG_W 5

`endif

/* hw/isaPkg.sv */
`default_nettype none

// RV32I encodings
package isaPkg;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [2:0] {
		BEQ  = 3'b000,
		BNE  = 3'b001,
		BLT  = 3'b100,
		BGE  = 3'b101,
		BLTU = 3'b110,
		BGEU = 3'b111
	} branchF3_e;

	typedef enum logic [2:0] {
		MEM_B  = 3'b000,
		MEM_H  = 3'b001,
		MEM_W  = 3'b010,
		MEM_BU = 3'b100,
		MEM_HU = 3'b101
	} memF3_e;

	// funct3 of OP and OP_IMM
	typedef enum logic [2:0] {
		F3_ADD  = 3'b000,
		F3_SLL  = 3'b001,
		F3_SLT  = 3'b010,
		F3_SLTU = 3'b011,
		F3_XOR  = 3'b100,
		F3_SR   = 3'b101, // SRL or SRA by funct7
		F3_OR   = 3'b110,
		F3_AND  = 3'b111
	} aluF3_e;

endpackage

`default_nettype wire

/* hw/corePkg.sv */
`default_nettype none
`include "riscv_settings.svh"

package corePkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`ADDR_W-1:0] addr_t;

	// Low ten are plain ALU ops, top six carry the branch compare
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
		ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
	} aluOp_e;

	typedef enum logic [2:0] {
		IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
	} immKind_e;

	typedef enum logic [1:0] {
		WB_ALU, WB_MEM, WB_PC4, WB_IMM
	} wbSel_e;

	typedef enum logic [1:0] {
		PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR
	} nextPc_e;

endpackage

`default_nettype wire

/* hw/controlDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module controlDecoder (
	input corePkg::word_t instr,
	output corePkg::aluOp_e aluOp,
	output corePkg::immKind_e immKind,
	output corePkg::wbSel_e wbSel,
	output corePkg::nextPc_e nextPcSel,
	output logic aluSrcImm,
	output logic aluSrcPc,
	output logic regWrite,
	output logic memWrite,
	output logic memRead,
	output logic isHalt
	);

	import isaPkg::*;
	import corePkg::*;

	localparam word_t EBREAK_WORD = 32'h0010_0073;

	logic [2:0] funct3;

	assign funct3 = instr[14:12];

	// SUB only exists in OP, SRA in both
	function automatic aluOp_e aluFromF3(input logic [2:0] f3, input logic alt, input logic isReg);
		aluOp_e op;
		case (aluF3_e'(f3))
			F3_ADD: op = (alt && isReg) ? ALU_SUB : ALU_ADD;
			F3_SLL: op = ALU_SLL;
			F3_SLT: op = ALU_SLT;
			F3_SLTU: op = ALU_SLTU;
			F3_XOR: op = ALU_XOR;
			F3_SR: op = alt ? ALU_SRA : ALU_SRL;
			F3_OR: op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	always_comb begin
		aluOp = ALU_ADD;
		immKind = IMM_I;
		wbSel = WB_ALU;
		nextPcSel = PC_SEQ;
		aluSrcImm = 1'b0;
		aluSrcPc = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memRead = 1'b0;
		isHalt = 1'b0;
		case (opcode_e'(instr[6:0]))
			OP: begin
				regWrite = 1'b1;
				aluOp = aluFromF3(funct3, instr[30], 1'b1);
			end
			OP_IMM: begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
				aluOp = aluFromF3(funct3, instr[30], 1'b0);
			end
			LUI: begin
				regWrite = 1'b1;
				immKind = IMM_U;
				wbSel = WB_IMM;
			end
			AUIPC: begin
				regWrite = 1'b1;
				immKind = IMM_U;
				aluSrcPc = 1'b1;
				aluSrcImm = 1'b1;
			end
			LOAD: begin
				regWrite = 1'b1;
				memRead = 1'b1;
				aluSrcImm = 1'b1;
				wbSel = WB_MEM;
			end
			STORE: begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
				immKind = IMM_S;
			end
			BRANCH: begin
				immKind = IMM_B;
				nextPcSel = PC_BRANCH;
				case (branchF3_e'(funct3))
					BEQ: aluOp = ALU_BEQ;
					BNE: aluOp = ALU_BNE;
					BLT: aluOp = ALU_BLT;
					BGE: aluOp = ALU_BGE;
					BLTU: aluOp = ALU_BLTU;
					BGEU: aluOp = ALU_BGEU;
					default: nextPcSel = PC_SEQ; // Reserved funct3, falls through
				endcase
			end
			JAL: begin
				regWrite = 1'b1;
				immKind = IMM_J;
				wbSel = WB_PC4;
				nextPcSel = PC_JAL;
			end
			JALR: begin
				regWrite = 1'b1;
				wbSel = WB_PC4;
				nextPcSel = PC_JALR;
			end
			SYSTEM: isHalt = (instr == EBREAK_WORD); // Only EBREAK acts
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hw/immGen.sv */
`timescale 1ns/10ps
`default_nettype none

module immGen (
	input corePkg::word_t instr,
	input corePkg::immKind_e immKind,
	output corePkg::word_t imm
	);

	import corePkg::*;

	logic sign;

	assign sign = instr[31];

	always_comb begin
		case (immKind)
			IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
			IMM_B: imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			IMM_U: imm = {instr[31:12], 12'b0};
			IMM_J: imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			default: imm = {{20{sign}}, instr[31:20]}; // I format
		endcase
	end

endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu (
	input corePkg::word_t a,
	input corePkg::word_t b,
	input corePkg::aluOp_e aluOp,
	output corePkg::word_t result,
	output logic branchTaken
	);

	import corePkg::*;

	logic [4:0] shamt;
	logic lessSigned;
	logic lessUnsigned;

	assign shamt = b[4:0];
	assign lessSigned = $signed(a) < $signed(b);
	assign lessUnsigned = a < b;

	always_comb begin
		case (aluOp)
			ALU_ADD: result = a + b;
			ALU_SLL: result = a << shamt;
			ALU_SLT: result = {31'b0, lessSigned};
			ALU_SLTU: result = {31'b0, lessUnsigned};
			ALU_XOR: result = a ^ b;
			ALU_SRL: result = a >> shamt;
			ALU_SRA: result = $signed(a) >>> shamt;
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			default: result = a - b; // SUB and all compares
		endcase
	end

	always_comb begin
		case (aluOp)
			ALU_BEQ: branchTaken = (a == b);
			ALU_BNE: branchTaken = (a != b);
			ALU_BLT: branchTaken = lessSigned;
			ALU_BGE: branchTaken = !lessSigned;
			ALU_BLTU: branchTaken = lessUnsigned;
			ALU_BGEU: branchTaken = !lessUnsigned;
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/pcUnit.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscv_settings.svh"

module pcUnit (
	input logic CLK,
	input logic RSTn,
	input corePkg::nextPc_e nextPcSel,
	input logic branchTaken,
	input corePkg::word_t imm,
	input corePkg::word_t jalrBase,
	input logic isHalt,
	output corePkg::addr_t pc,
	output corePkg::word_t pcPlus4,
	output logic HALT,
	output corePkg::word_t NUM_INST
	);

	import corePkg::*;

	logic haltQ;
	word_t pcTarget;
	word_t jalrTarget;
	word_t nextPc;

	assign pcPlus4 = word_t'(pc) + 32'd4;
	assign pcTarget = word_t'(pc) + imm; // Branch and JAL
	assign jalrTarget = (jalrBase + imm) & ~32'd1;
	assign HALT = haltQ | isHalt; // High already in the EBREAK cycle

	always_comb begin
		case (nextPcSel)
			PC_BRANCH: nextPc = branchTaken ? pcTarget : pcPlus4;
			PC_JAL: nextPc = pcTarget;
			PC_JALR: nextPc = jalrTarget;
			default: nextPc = pcPlus4;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc <= '0;
			NUM_INST <= '0;
			haltQ <= 1'b0;
		end else begin
			haltQ <= HALT;
			if (!HALT) begin
				pc <= nextPc[`ADDR_W-1:0];
				NUM_INST <= NUM_INST + 32'd1;
			end
		end
	end

	assert property (@(posedge CLK) disable iff (RSTn) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hw/lsuAlign.sv */
`timescale 1ns/10ps
`default_nettype none

module lsuAlign (
	input logic [1:0] addrLow,
	input isaPkg::memF3_e funct3,
	input logic memWrite,
	input corePkg::word_t storeData,
	input corePkg::word_t memReadData,
	output logic [3:0] byteEnable,
	output corePkg::word_t writeData,
	output corePkg::word_t loadData
	);

	import isaPkg::*;
	import corePkg::*;

	logic [7:0] loadByte;
	logic [15:0] loadHalf;

	assign loadByte = memReadData[8*addrLow +: 8];
	assign loadHalf = addrLow[1] ? memReadData[31:16] : memReadData[15:0];

	always_comb begin
		case (funct3)
			MEM_B, MEM_BU: begin
				writeData = {4{storeData[7:0]}};
				byteEnable = 4'b0001 << addrLow;
			end
			MEM_H, MEM_HU: begin
				writeData = {2{storeData[15:0]}};
				byteEnable = addrLow[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				writeData = storeData;
				byteEnable = 4'b1111;
			end
		endcase
		if (!memWrite)
			byteEnable = 4'b0000; // Lanes only on stores
	end

	always_comb begin
		case (funct3)
			MEM_B: loadData = {{24{loadByte[7]}}, loadByte};
			MEM_BU: loadData = {24'b0, loadByte};
			MEM_H: loadData = {{16{loadHalf[15]}}, loadHalf};
			MEM_HU: loadData = {16'b0, loadHalf};
			default: loadData = memReadData;
		endcase
	end

endmodule

`default_nettype wire

/* hw/RISCV_TOP.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscv_settings.svh"

module RISCV_TOP (
	input logic CLK,
	input logic RSTn,

	output logic I_MEM_CSN,
	input corePkg::word_t I_MEM_DI,
	output corePkg::addr_t I_MEM_ADDR, // Byte address

	output logic D_MEM_CSN,
	input corePkg::word_t D_MEM_DI,
	output corePkg::word_t D_MEM_DOUT, // Lane replicated
	output corePkg::addr_t D_MEM_ADDR, // Byte address
	output logic D_MEM_WEN,
	output logic [3:0] D_MEM_BE,

	output logic RF_WE,
	output logic [`REG_W-1:0] RF_RA1,
	output logic [`REG_W-1:0] RF_RA2,
	output logic [`REG_W-1:0] RF_WA1,
	input corePkg::word_t RF_RD1,
	input corePkg::word_t RF_RD2,
	output corePkg::word_t RF_WD,
	output logic HALT,
	output corePkg::word_t NUM_INST,
	output corePkg::word_t OUTPUT_PORT
	);

	import isaPkg::*;
	import corePkg::*;

	aluOp_e aluOp;
	immKind_e immKind;
	wbSel_e wbSel;
	nextPc_e nextPcSel;
	logic aluSrcImm, aluSrcPc;
	logic regWrite, memWrite, memRead, isHalt;
	logic branchTaken;
	logic commitOk;
	word_t imm, opA, opB, aluResult, pcPlus4, loadData;

	assign RF_RA1 = I_MEM_DI[19:15];
	assign RF_RA2 = I_MEM_DI[24:20];
	assign RF_WA1 = I_MEM_DI[11:7];

	controlDecoder u_decoder (
		.instr(I_MEM_DI), .aluOp(aluOp), .immKind(immKind), .wbSel(wbSel),
		.nextPcSel(nextPcSel), .aluSrcImm(aluSrcImm), .aluSrcPc(aluSrcPc),
		.regWrite(regWrite), .memWrite(memWrite), .memRead(memRead), .isHalt(isHalt)
	);

	immGen u_immGen (.instr(I_MEM_DI), .immKind(immKind), .imm(imm));

	assign opA = aluSrcPc ? word_t'(I_MEM_ADDR) : RF_RD1;
	assign opB = aluSrcImm ? imm : RF_RD2;

	alu u_alu (
		.a(opA), .b(opB), .aluOp(aluOp), .result(aluResult), .branchTaken(branchTaken)
	);

	pcUnit u_pc (
		.CLK(CLK), .RSTn(RSTn), .nextPcSel(nextPcSel), .branchTaken(branchTaken),
		.imm(imm), .jalrBase(RF_RD1), .isHalt(isHalt), .pc(I_MEM_ADDR),
		.pcPlus4(pcPlus4), .HALT(HALT), .NUM_INST(NUM_INST)
	);

	assign D_MEM_ADDR = aluResult[`ADDR_W-1:0];

	lsuAlign u_lsu (
		.addrLow(aluResult[1:0]), .funct3(memF3_e'(I_MEM_DI[14:12])), .memWrite(memWrite),
		.storeData(RF_RD2), .memReadData(D_MEM_DI), .byteEnable(D_MEM_BE),
		.writeData(D_MEM_DOUT), .loadData(loadData)
	);

	always_comb begin
		case (wbSel)
			WB_MEM: RF_WD = loadData;
			WB_PC4: RF_WD = pcPlus4; // Link value
			WB_IMM: RF_WD = imm;
			default: RF_WD = aluResult;
		endcase
	end

	// No commits in reset or after EBREAK
	assign commitOk = !RSTn && !HALT;
	assign RF_WE = regWrite && commitOk;
	assign D_MEM_WEN = !(memWrite && commitOk);
	assign I_MEM_CSN = RSTn;
	assign D_MEM_CSN = RSTn || !(memRead || memWrite);
	assign OUTPUT_PORT = RF_WD;

	// Misaligned data accesses are unsupported
	assert property (@(posedge CLK) disable iff (RSTn)
		(memRead || memWrite) && I_MEM_DI[13] |-> aluResult[1:0] == 2'b00);
	assert property (@(posedge CLK) disable iff (RSTn)
		(memRead || memWrite) && I_MEM_DI[12] |-> !aluResult[0]);

endmodule

`default_nettype wire

/* verification/tb_isaModel.svh */
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic word_t randBits(input int n);
	word_t r;
	logic fb;
	r = '0;
	for (int i = 0; i < n; i++) begin
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		r = {r[30:0], fb};
	end
	return r;
endfunction

task automatic emit(input word_t ins, input int test);
	imem[progLen] = ins;
	testOf[progLen] = test;
	progLen++;
endtask

task automatic buildProgram();
	int aluF3 [10] = '{0, 0, 7, 6, 4, 2, 3, 1, 5, 5};
	int immF3 [6] = '{0, 2, 3, 4, 6, 7};
	int ldF3 [7] = '{1, 1, 1, 5, 5, 2, 2};
	int ldAdr [7] = '{'h104, 'h106, 'h10a, 'h106, 'h202, 'h108, 'h300};
	int brF3 [8] = '{0, 1, 4, 5, 6, 7, 0, 1};
	word_t r;
	for (int k = 0; k < 10; k++)
		emit({(k == 1 || k == 9) ? 7'h20 : 7'h00, 5'(k + 2), 5'(k + 1), 3'(aluF3[k]),
			5'(16 + k), 7'h33}, 1);
	for (int k = 0; k < 6; k++) begin
		r = randBits(12);
		emit({r[11:0], 5'(k + 1), 3'(immF3[k]), 5'(16 + k), 7'h13}, 1);
	end
	for (int k = 0; k < 3; k++) begin
		r = randBits(5); // Shift amount only
		emit({k == 2 ? 7'h20 : 7'h00, r[4:0], 5'(k + 3), k == 0 ? 3'd1 : 3'd5,
			5'(22 + k), 7'h13}, 1);
	end
	r = randBits(20);
	emit({r[19:0], 5'd26, 7'h37}, 2);
	r = randBits(20);
	emit({r[19:0], 5'd27, 7'h17}, 2);
	// Stores relative to x0, SB at every byte offset
	for (int k = 0; k < 4; k++)
		emit({7'h08, 5'(k + 1), 5'd0, 3'd0, 5'(k), 7'h23}, 3);
	emit({7'h08, 5'd5, 5'd0, 3'd1, 5'd4, 7'h23}, 3);
	emit({7'h08, 5'd6, 5'd0, 3'd1, 5'd6, 7'h23}, 3);
	emit({7'h08, 5'd7, 5'd0, 3'd2, 5'd8, 7'h23}, 3);
	for (int k = 0; k < 4; k++) begin
		emit({12'(12'h100 + k), 5'd0, 3'd0, 5'd28, 7'h03}, 3);
		emit({12'(12'h100 + k), 5'd0, 3'd4, 5'd28, 7'h03}, 3);
	end
	for (int k = 0; k < 7; k++)
		emit({12'(ldAdr[k]), 5'd0, 3'(ldF3[k]), 5'd28, 7'h03}, 3);
	// Every branch jumps +8 over one counter increment
	for (int k = 0; k < 8; k++) begin
		emit({7'b0, k < 6 ? 5'(k + 2) : 5'd1, k < 6 ? 5'(k + 1) : 5'd1, 3'(brF3[k]),
			5'b01000, 7'h63}, 4);
		emit({12'd1, 5'd29, 3'd0, 5'd29, 7'h13}, 4);
	end
	emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd21, 7'h6f}, 4);
	emit({12'd1, 5'd29, 3'd0, 5'd29, 7'h13}, 4);
	emit({20'd0, 5'd23, 7'h17}, 4);
	emit({12'd12, 5'd23, 3'd0, 5'd22, 7'h67}, 4); // Lands past the next word
	emit({12'd1, 5'd29, 3'd0, 5'd29, 7'h13}, 4);
	emit(32'h0010_0073, 5);
endtask

// One instruction on the shadow state
function automatic void refStep(output logic we, output logic st, output logic halt,
	output logic [4:0] wa, output word_t wd, output addr_t sAddr, output logic [3:0] be,
	output word_t sData);
	word_t ins, a, b, opb, iImm, sImm, bImm, nextPc, w, ea;
	logic [2:0] f3;
	logic [7:0] by;
	logic [15:0] hw;
	logic tk;
	ins = imem[pcM[11:2]];
	f3 = ins[14:12];
	a = regM[ins[19:15]];
	b = regM[ins[24:20]];
	iImm = {{20{ins[31]}}, ins[31:20]};
	sImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
	bImm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
	we = 0;
	st = 0;
	halt = 0;
	wa = ins[11:7];
	wd = '0;
	sAddr = '0;
	be = '0;
	sData = '0;
	nextPc = pcM + 4;
	case (ins[6:0])
		7'h33, 7'h13: begin
			we = 1;
			opb = ins[5] ? b : iImm;
			case (f3)
				0: wd = (ins[5] && ins[30]) ? a - opb : a + opb;
				1: wd = a << opb[4:0];
				2: wd = word_t'($signed(a) < $signed(opb));
				3: wd = word_t'(a < opb);
				4: wd = a ^ opb;
				5: if (ins[30]) wd = $signed(a) >>> opb[4:0];
					else wd = a >> opb[4:0];
				6: wd = a | opb;
				default: wd = a & opb;
			endcase
		end
		7'h37: begin
			we = 1;
			wd = {ins[31:12], 12'b0};
		end
		7'h17: begin
			we = 1;
			wd = pcM + {ins[31:12], 12'b0};
		end
		7'h03: begin
			we = 1;
			ea = a + iImm;
			w = memM[ea[11:2]];
			by = w[8*ea[1:0] +: 8];
			hw = ea[1] ? w[31:16] : w[15:0];
			case (f3)
				0: wd = {{24{by[7]}}, by};
				4: wd = {24'b0, by};
				1: wd = {{16{hw[15]}}, hw};
				5: wd = {16'b0, hw};
				default: wd = w;
			endcase
		end
		7'h23: begin
			st = 1;
			ea = a + sImm;
			sAddr = ea[11:0];
			case (f3)
				0: begin
					be = 4'b0001 << ea[1:0];
					sData = {4{b[7:0]}};
				end
				1: begin
					be = ea[1] ? 4'b1100 : 4'b0011;
					sData = {2{b[15:0]}};
				end
				default: begin
					be = 4'b1111;
					sData = b;
				end
			endcase
			for (int k = 0; k < 4; k++)
				if (be[k])
					memM[ea[11:2]][8*k +: 8] = sData[8*k +: 8];
		end
		7'h63: begin
			case (f3)
				0: tk = a == b;
				1: tk = a != b;
				4: tk = $signed(a) < $signed(b);
				5: tk = $signed(a) >= $signed(b);
				6: tk = a < b;
				default: tk = a >= b;
			endcase
			if (tk)
				nextPc = pcM + bImm;
		end
		7'h6f: begin
			we = 1;
			wd = pcM + 4;
			nextPc = pcM + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		end
		7'h67: begin
			we = 1;
			wd = pcM + 4;
			nextPc = (a + iImm) & ~32'd1;
		end
		7'h73: begin
			halt = 1;
			nextPc = pcM;
		end
		default: ;
	endcase
	if (we && wa != 0)
		regM[wa] = wd;
	pcM = nextPc;
endfunction

`endif

/* verification/tb_riscvTop.sv */
`timescale 1ns/10ps
`default_nettype none
`include "riscv_settings.svh"

module tb_riscvTop;
	import corePkg::*;

	logic CLK, RSTn;
	logic I_MEM_CSN, D_MEM_CSN, D_MEM_WEN, RF_WE, HALT;
	addr_t I_MEM_ADDR, D_MEM_ADDR;
	word_t I_MEM_DI, D_MEM_DI, D_MEM_DOUT, RF_RD1, RF_RD2, RF_WD, NUM_INST, OUTPUT_PORT;
	logic [3:0] D_MEM_BE;
	logic [`REG_W-1:0] RF_RA1, RF_RA2, RF_WA1;

	word_t imem [0:1023];
	word_t dmem [0:1023];
	word_t memM [0:1023];
	word_t rf [0:31];
	word_t regM [0:31];
	int testOf [0:1023];
	string testName [6] = '{"reset", "alu", "upper", "memory", "branch", "halt"};
	int testErr [6];
	logic [15:0] lfsr = 16'd69;
	word_t pcM, retired, eWd, eSData;
	int progLen, checks, errors, curTest, holdCycles;
	logic running, done, haltedM, eWe, eSt, eHalt, eLd;
	logic [4:0] eWa;
	addr_t eSAddr;
	logic [3:0] eBe;

	`include "tb_isaModel.svh"

	RISCV_TOP u_dut (.*);

	assign I_MEM_DI = imem[I_MEM_ADDR[11:2]];
	assign D_MEM_DI = dmem[D_MEM_ADDR[11:2]];
	assign RF_RD1 = rf[RF_RA1];
	assign RF_RD2 = rf[RF_RA2];

	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		if (RF_WE && RF_WA1 != 0)
			rf[RF_WA1] <= RF_WD; // x0 stays zero
		for (int k = 0; k < 4; k++)
			if (!D_MEM_WEN && D_MEM_BE[k])
				dmem[D_MEM_ADDR[11:2]][8*k +: 8] <= D_MEM_DOUT[8*k +: 8];
	end

	task automatic checkWord(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
			testErr[curTest]++;
		end
	endtask

	task automatic checkAddr(input addr_t got, input addr_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errors++;
			testErr[curTest]++;
		end
	endtask

	task automatic checkBe(input logic [3:0] got, input logic [3:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			errors++;
			testErr[curTest]++;
		end
	endtask

	task automatic reportTest(input int t);
		$display("Test %-7s finished with %0d errors", testName[t], testErr[t]);
	endtask

	initial begin
		CLK = 0;
		RSTn = 1;
		running = 0;
		done = 0;
		haltedM = 0;
		progLen = 0;
		checks = 0;
		errors = 0;
		curTest = 0;
		holdCycles = 0;
		pcM = '0;
		retired = '0;
		for (int i = 0; i < 1024; i++) begin
			imem[i] = '0;
			dmem[i] = (word_t'(i) * 32'h9E37_79B1) ^ 32'hA5A5_5A5A;
			memM[i] = dmem[i];
		end
		regM[0] = '0;
		for (int i = 1; i < 32; i++)
			regM[i] = randBits(32);
		rf = regM;
		buildProgram();
		for (int i = 0; i < 8; i++) begin
			@(posedge CLK);
			if (i > 0) begin
				checkAddr(I_MEM_ADDR, '0, "I_MEM_ADDR in reset");
				checkWord(NUM_INST, '0, "NUM_INST in reset");
				checkWord(word_t'({RF_WE, D_MEM_WEN, HALT}), 32'b010, "RF_WE/D_MEM_WEN/HALT");
				checkWord(word_t'({I_MEM_CSN, D_MEM_CSN}), 32'b11, "I_MEM_CSN/D_MEM_CSN");
			end
		end
		RSTn <= 0;
		running <= 1;
		reportTest(0);
		curTest = 1;
		wait (done);
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	always @(posedge CLK) begin
		if (running && !done) begin
			checkAddr(I_MEM_ADDR, pcM[`ADDR_W-1:0], "I_MEM_ADDR");
			checkWord(NUM_INST, retired, "NUM_INST");
			if (!haltedM) begin
				if (testOf[pcM[11:2]] != curTest) begin
					reportTest(curTest);
					curTest = testOf[pcM[11:2]];
				end
				eLd = (imem[pcM[11:2]][6:0] == 7'h03);
				refStep(eWe, eSt, eHalt, eWa, eWd, eSAddr, eBe, eSData);
				checkWord(word_t'({RF_WE, D_MEM_WEN, HALT}), word_t'({eWe, !eSt, eHalt}),
					"RF_WE/D_MEM_WEN/HALT");
				checkWord(word_t'({I_MEM_CSN, D_MEM_CSN}), word_t'({1'b0, !(eLd || eSt)}),
					"I_MEM_CSN/D_MEM_CSN");
				checkBe(D_MEM_BE, eBe, "D_MEM_BE");
				if (eWe) begin
					checkWord(word_t'(RF_WA1), word_t'(eWa), "RF_WA1");
					checkWord(RF_WD, eWd, "RF_WD");
					checkWord(OUTPUT_PORT, eWd, "OUTPUT_PORT");
				end
				if (eSt) begin
					checkAddr(D_MEM_ADDR, eSAddr, "D_MEM_ADDR");
					checkWord(D_MEM_DOUT, eSData, "D_MEM_DOUT");
				end
				if (eHalt)
					haltedM = 1;
				else
					retired++;
			end else begin
				// Frozen core, nothing commits
				checkWord(word_t'({RF_WE, D_MEM_WEN, HALT}), 32'b011, "RF_WE/D_MEM_WEN/HALT");
				checkWord(word_t'({I_MEM_CSN, D_MEM_CSN}), 32'b01, "I_MEM_CSN/D_MEM_CSN");
				holdCycles++;
				if (holdCycles == 5) begin
					reportTest(curTest);
					done = 1;
				end
			end
		end
	end

	initial begin
		wait (progLen > 0);
		#((progLen + 50) * 20);
		$display("Timeout: the core did not halt in the expected time");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+hw
+incdir+verification
hw/isaPkg.sv
hw/corePkg.sv
hw/controlDecoder.sv
hw/immGen.sv
hw/alu.sv
hw/pcUnit.sv
hw/lsuAlign.sv
hw/RISCV_TOP.sv
verification/tb_riscvTop.sv

/* Makefile */
TOP := tb_riscvTop

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf obj_dir
